/* bench/riscv_icu_chk.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_icu_chk (
  input logic i_clk,
  input logic i_rst_n,
  input logic i_branch_flag,
  input logic i_taken,
  input logic i_valid
);

  // no result can be pending in the first cycle out of reset.
  valid_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_valid)
    else $error("result valid was high in the first cycle after reset");

  taken_needs_branch: assert property (@(posedge i_clk) !i_branch_flag |-> !i_taken)
    else $error("branch taken without the branch flag set");

  valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n) !$isunknown(i_valid))
    else $error("result valid is unknown after reset");

endmodule

bind riscv_icu riscv_icu_chk u_chk (
  .i_clk         (i_riscv_icu_clk),
  .i_rst_n       (i_rst_n),
  .i_branch_flag (i_riscv_icu_bcond[3]),
  .i_taken       (o_riscv_branch_taken),
  .i_valid       (o_riscv_icu_valid)
);

`default_nettype wire

/* bench/riscv_icu_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_icu_tb import riscv_icu_pkg::*; ();

  localparam int MUL_STAGES  = 2;
  localparam int DIV_LAT     = DIV_ITERS + 2;
  localparam int N_ALU       = 300;
  localparam int N_BR        = 200;
  localparam int N_MUL       = 60;
  localparam int N_DIV       = 40;
  localparam int WATCHDOG_NS = 2 * (N_ALU + N_BR + N_MUL + N_DIV + 1) * 70 * 40;

  logic      clk = 1'b0;
  logic      rst_n;
  funcsel_t  funcsel;
  xlen_t     rs1, rs2, alu_a, alu_b;
  bcond_t    bcond;
  mulctrl_t  mulctrl;
  divctrl_t  divctrl;
  alu_ctrl_t aluctrl;
  logic      taken;
  logic      valid;
  xlen_t     result;
  logic [31:0] lfsr = 32'he786;
  int        cyc = 0;
  int        checks = 0;
  int        errors = 0;
  xlen_t     exp_q[$];  // expected results of multiply and divide, oldest first.
  int        due_q[$];  // cycle in which each of them must show up.

  riscv_icu #(.MUL_STAGES(MUL_STAGES)) i_riscv_icu (
    .i_riscv_icu_clk(clk), .i_rst_n(rst_n), .i_riscv_icu_funcsel(funcsel),
    .i_riscv_icu_rs1data(rs1), .i_riscv_icu_rs2data(rs2),
    .i_riscv_icu_alurs1data(alu_a), .i_riscv_icu_alurs2data(alu_b),
    .i_riscv_icu_bcond(bcond), .i_riscv_icu_mulctrl(mulctrl),
    .i_riscv_icu_divctrl(divctrl), .i_riscv_icu_aluctrl(aluctrl),
    .o_riscv_branch_taken(taken), .o_riscv_icu_valid(valid), .o_riscv_icu_result(result)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // 32-bit fibonacci lfsr with taps 32, 22, 2 and 1.
  function automatic xlen_t rnd(input int n);
    xlen_t r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic xlen_t pick_operand();
    case (3'(rnd(3)))
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return {1'b1, 63'd0};
      3'd3: return (rnd(1) != 0) ? 64'hffff_ffff_8000_0000 : 64'h0000_0000_7fff_ffff;
      3'd4: return (rnd(1) != 0) ? 64'h0000_0000_ffff_ffff : 64'h0000_0000_8000_0000;
      3'd5: return rnd(6);  // small values exercise the shifts.
      default: return rnd(64);
    endcase
  endfunction

  function automatic xlen_t alu_model(input alu_ctrl_t ctrl, input xlen_t a, input xlen_t b);
    word_t w = '0;
    case (ctrl)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_SLL:   return a << b[5:0];
      ALU_SLT:   return xlen_t'($signed(a) < $signed(b));
      ALU_SLTU:  return xlen_t'(a < b);
      ALU_XOR:   return a ^ b;
      ALU_SRL:   return a >> b[5:0];
      ALU_SRA:   return $signed(a) >>> b[5:0];
      ALU_OR:    return a | b;
      ALU_AND:   return a & b;
      ALU_ADDW:  w = a[31:0] + b[31:0];
      ALU_SUBW:  w = a[31:0] - b[31:0];
      ALU_SLLW:  w = a[31:0] << b[4:0];
      ALU_SRLW:  w = a[31:0] >> b[4:0];
      ALU_SRAW:  w = $signed(a[31:0]) >>> b[4:0];
      ALU_PASS2: return b;
      default:   return '0;
    endcase
    return {{32{w[31]}}, w};  // word results are sign extended.
  endfunction

  function automatic logic branch_model(input bcond_t c, input xlen_t a, input xlen_t b);
    if (!c[3]) return 1'b0;
    case (c[2:0])
      BR_EQ:   return a == b;
      BR_NE:   return a != b;
      BR_LT:   return $signed(a) < $signed(b);
      BR_GE:   return $signed(a) >= $signed(b);
      BR_LTU:  return a < b;
      BR_GEU:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t mul_model(input logic [2:0] op, input xlen_t a, input xlen_t b);
    logic [127:0] ea;
    logic [127:0] eb;
    logic [127:0] p;
    ea = {{64{(op == MUL_HSS || op == MUL_HSU) & a[63]}}, a};
    eb = {{64{(op == MUL_HSS) & b[63]}}, b};
    p  = ea * eb;  // the low 128 bits are right for every signedness.
    case (op)
      MUL_LO:  return p[63:0];
      MUL_W:   return {{32{p[31]}}, p[31:0]};
      default: return p[127:64];
    endcase
  endfunction

  function automatic xlen_t div_model(input logic [2:0] op, input xlen_t a, input xlen_t b);
    logic  uns;
    logic  rem;
    xlen_t r;
    uns = op[0];
    rem = op[1];
    if (op[2]) begin  // word forms work on widened low halves.
      a = uns ? {32'd0, a[31:0]} : {{32{a[31]}}, a[31:0]};
      b = uns ? {32'd0, b[31:0]} : {{32{b[31]}}, b[31:0]};
    end
    if (b == '0) begin
      r = rem ? a : '1;
    end else if (!uns && a == {1'b1, 63'd0} && b == '1) begin
      r = rem ? '0 : a;
    end else if (uns) begin
      r = rem ? a % b : a / b;
    end else if (rem) begin
      r = $signed(a) % $signed(b);
    end else begin
      r = $signed(a) / $signed(b);
    end
    return op[2] ? {{32{r[31]}}, r[31:0]} : r;
  endfunction

  task automatic check_true(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("%s, at %0t ns", msg, $time);
    end
  endtask

  task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t %s result %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic next_drive();
    @(posedge clk);
    #5;
  endtask

  // runs at the falling edge and matches a valid pulse against the oldest expectation.
  task automatic collect_result(input string what);
    if (valid === 1'b1) begin
      check_true(due_q.size() > 0 && due_q[0] == cyc, {what, " valid came at a wrong cycle"});
      if (exp_q.size() > 0) begin
        check_value(what, result, exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
      check_true(1'b0, {what, " valid pulse never arrived"});
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
    end
  endtask

  task automatic mul_burst(input int len);
    logic [2:0] op;
    for (int k = 0; k < len + MUL_STAGES + 2; k++) begin
      next_drive();
      funcsel = FSEL_MUL;
      mulctrl = '0;
      if (k < len) begin
        op = 3'(rnd(3) % 5);
        alu_a = pick_operand();
        alu_b = pick_operand();
        mulctrl = {1'b1, op};
        exp_q.push_back(mul_model(op, alu_a, alu_b));
        due_q.push_back(cyc + MUL_STAGES);
      end
      @(negedge clk);
      collect_result("mul");
    end
  endtask

  // one divide, with an optional second start while it runs.
  task automatic div_op(input logic [2:0] op, input xlen_t a, input xlen_t b, input int again);
    int span;
    span = DIV_LAT + 3;
    if (again >= 0) begin
      span += DIV_LAT + again;  // a second start that was taken would end inside this window.
    end
    next_drive();
    funcsel = FSEL_DIV;
    alu_a = a;
    alu_b = b;
    divctrl = {1'b1, op};
    exp_q.push_back(div_model(op, a, b));
    due_q.push_back(cyc + DIV_LAT);
    for (int k = 0; k < span; k++) begin
      @(negedge clk);
      collect_result("div");
      next_drive();
      divctrl = (k == again) ? {1'b1, REM_SW} : '0;
      alu_a = rnd(64);  // operands only count at the start.
      alu_b = rnd(64);
    end
    divctrl = '0;
  endtask

  initial begin
    logic [2:0] op;
    xlen_t a;
    xlen_t b;
    int left;
    int len;
    rst_n = 1'b0;
    funcsel = FSEL_ALU;
    {rs1, rs2, alu_a, alu_b} = '0;
    bcond = '0;
    mulctrl = '0;
    divctrl = '0;
    aluctrl = ALU_ADD;
    for (int k = 0; k < 8 + 5; k++) begin
      next_drive();
      rst_n = (k >= 7);
      @(negedge clk);
      check_true(valid === 1'b0, "valid was not low around reset");
    end
    for (int i = 0; i < N_ALU; i++) begin
      next_drive();
      aluctrl = alu_ctrl_t'(rnd(4));
      alu_a = pick_operand();
      alu_b = pick_operand();
      @(negedge clk);
      check_value("alu", result, alu_model(aluctrl, alu_a, alu_b));
    end
    for (int i = 0; i < N_BR; i++) begin
      next_drive();
      bcond = bcond_t'({rnd(1), 3'(i % 8)});
      rs1 = pick_operand();
      rs2 = (rnd(2) == 0) ? rs1 : pick_operand();
      @(negedge clk);
      check_value("branch", xlen_t'(taken), xlen_t'(branch_model(bcond, rs1, rs2)));
    end
    next_drive();
    bcond = '0;
    left = N_MUL;
    while (left > 0) begin
      len = 1 + int'(rnd(3));
      len = (len > left) ? left : len;
      mul_burst(len);
      left -= len;
    end
    for (int i = 0; i < N_DIV; i++) begin
      op = 3'(i % 8);
      a = pick_operand();
      b = pick_operand();
      if (i < 8) begin
        b = op[2] ? rnd(32) << 32 : '0;  // zero divisor, upper half ignored by w forms.
      end else if (i < 16) begin
        a = op[2] ? (rnd(32) << 32) | 64'h8000_0000 : {1'b1, 63'd0};
        b = op[2] ? (rnd(32) << 32) | 64'hffff_ffff : '1;
      end
      div_op(op, a, b, -1);
    end
    div_op(DIV_U, 64'd1000, 64'd7, 5);
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/riscv_alu.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_alu import riscv_icu_pkg::*; (
  input  alu_ctrl_t i_riscv_alu_ctrl,
  input  xlen_t     i_riscv_alu_rs1data,
  input  xlen_t     i_riscv_alu_rs2data,
  output xlen_t     o_riscv_alu_result
);

  logic [5:0] shamt;
  logic [4:0] shamt_w;
  logic       lt;
  logic       ltu;
  word_t      rs1_w;
  word_t      rs2_w;

  assign shamt   = i_riscv_alu_rs2data[5:0];  // rv64 shifts use six bits.
  assign shamt_w = i_riscv_alu_rs2data[4:0];  // word shifts ignore bit 5.
  assign rs1_w   = i_riscv_alu_rs1data[31:0];
  assign rs2_w   = i_riscv_alu_rs2data[31:0];

  assign lt  = $signed(i_riscv_alu_rs1data) < $signed(i_riscv_alu_rs2data);
  assign ltu = i_riscv_alu_rs1data < i_riscv_alu_rs2data;

  always_comb begin
    case (i_riscv_alu_ctrl)
      ALU_ADD: begin
        o_riscv_alu_result = i_riscv_alu_rs1data + i_riscv_alu_rs2data;
      end
      ALU_SUB: begin
        o_riscv_alu_result = i_riscv_alu_rs1data - i_riscv_alu_rs2data;
      end
      ALU_SLL: begin
        o_riscv_alu_result = i_riscv_alu_rs1data << shamt;
      end
      ALU_SLT: begin
        o_riscv_alu_result = {63'd0, lt};
      end
      ALU_SLTU: begin
        o_riscv_alu_result = {63'd0, ltu};
      end
      ALU_XOR: begin
        o_riscv_alu_result = i_riscv_alu_rs1data ^ i_riscv_alu_rs2data;
      end
      ALU_SRL: begin
        o_riscv_alu_result = i_riscv_alu_rs1data >> shamt;
      end
      ALU_SRA: begin
        o_riscv_alu_result = $signed(i_riscv_alu_rs1data) >>> shamt;
      end
      ALU_OR: begin
        o_riscv_alu_result = i_riscv_alu_rs1data | i_riscv_alu_rs2data;
      end
      ALU_AND: begin
        o_riscv_alu_result = i_riscv_alu_rs1data & i_riscv_alu_rs2data;
      end
      ALU_ADDW: begin
        o_riscv_alu_result = sext_w(rs1_w + rs2_w);  // carry out of bit 31 is dropped.
      end
      ALU_SUBW: begin
        o_riscv_alu_result = sext_w(rs1_w - rs2_w);
      end
      ALU_SLLW: begin
        o_riscv_alu_result = sext_w(rs1_w << shamt_w);
      end
      ALU_SRLW: begin
        o_riscv_alu_result = sext_w(rs1_w >> shamt_w);  // zeros shift in at bit 31.
      end
      ALU_SRAW: begin
        o_riscv_alu_result = sext_w($signed(rs1_w) >>> shamt_w);
      end
      ALU_PASS2: begin
        o_riscv_alu_result = i_riscv_alu_rs2data;
      end
      default: begin
        o_riscv_alu_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/riscv_branch.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_branch import riscv_icu_pkg::*; (
  input  bcond_t i_riscv_branch_cond,
  input  xlen_t  i_riscv_branch_rs1data,
  input  xlen_t  i_riscv_branch_rs2data,
  output logic   o_riscv_branch_taken
);

  logic eq;
  logic lt;
  logic ltu;
  logic cond;

  assign eq  = i_riscv_branch_rs1data == i_riscv_branch_rs2data;
  assign lt  = $signed(i_riscv_branch_rs1data) < $signed(i_riscv_branch_rs2data);
  assign ltu = i_riscv_branch_rs1data < i_riscv_branch_rs2data;

  always_comb begin
    case (i_riscv_branch_cond[2:0])
      BR_EQ:   cond = eq;
      BR_NE:   cond = !eq;
      BR_LT:   cond = lt;
      BR_GE:   cond = !lt;
      BR_LTU:  cond = ltu;
      BR_GEU:  cond = !ltu;
      default: cond = 1'b0;  // funct3 010 and 011 encode no branch.
    endcase
  end

  // non-branch instructions share the operand path, so the flag gates the result.
  assign o_riscv_branch_taken = i_riscv_branch_cond[3] & cond;

endmodule

`default_nettype wire

/* rtl/riscv_divider.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_divider import riscv_icu_pkg::*; (
  input  logic     i_riscv_div_clk,
  input  logic     i_rst_n,
  input  xlen_t    i_riscv_div_rs1data,
  input  xlen_t    i_riscv_div_rs2data,
  input  divctrl_t i_riscv_div_divctrl,
  output logic     o_riscv_div_valid,
  output xlen_t    o_riscv_div_result
);

  localparam int CNT_W = $clog2(DIV_ITERS);

  div_state_t state;
  logic [CNT_W-1:0] count;
  logic       start;
  logic [2:0] op;
  logic       is_signed;
  xlen_t      dvd_val;  // dividend after word truncation and extension.
  xlen_t      dvs_val;
  xlen_t      dvd_min;
  logic       dvd_neg;
  logic       dvs_neg;
  logic       op_w_q;
  logic       op_rem_q;
  logic       neg_quo_q;
  logic       neg_rem_q;
  logic       div0_q;
  logic       ovf_q;
  xlen_t      dividend_q;
  xlen_t      divisor_q;
  xlen_t      quo_q;
  xlen_t      part_q;  // partial remainder.
  logic [64:0] shifted;
  logic [65:0] trial;
  xlen_t      raw_res;

  assign start     = i_riscv_div_divctrl[3];
  assign op        = i_riscv_div_divctrl[2:0];
  assign is_signed = !op[0];

  assign dvd_val = !op[2] ? i_riscv_div_rs1data :
                   is_signed ? sext_w(i_riscv_div_rs1data[31:0]) :
                   {32'd0, i_riscv_div_rs1data[31:0]};
  assign dvs_val = !op[2] ? i_riscv_div_rs2data :
                   is_signed ? sext_w(i_riscv_div_rs2data[31:0]) :
                   {32'd0, i_riscv_div_rs2data[31:0]};
  assign dvd_min = op[2] ? sext_w(32'h8000_0000) : {1'b1, 63'd0};
  assign dvd_neg = is_signed & dvd_val[63];
  assign dvs_neg = is_signed & dvs_val[63];

  // trial subtraction of one restoring step.
  assign shifted = {part_q, quo_q[63]};
  assign trial   = {1'b0, shifted} - {2'b00, divisor_q};

  always_comb begin
    if (div0_q) begin
      raw_res = op_rem_q ? dividend_q : '1;
    end else if (ovf_q) begin
      raw_res = op_rem_q ? '0 : dividend_q;
    end else if (op_rem_q) begin
      raw_res = neg_rem_q ? -part_q : part_q;  // remainder takes the dividend sign.
    end else begin
      raw_res = neg_quo_q ? -quo_q : quo_q;
    end
  end

  always_ff @(posedge i_riscv_div_clk) begin
    if (!i_rst_n) begin
      state              <= DIV_IDLE;
      count              <= '0;
      o_riscv_div_valid  <= 1'b0;
      o_riscv_div_result <= '0;
    end else begin
      o_riscv_div_valid <= 1'b0;
      case (state)
        DIV_IDLE: begin
          if (start) begin  // starts in other states are dropped.
            state <= DIV_RUN;
            count <= '0;
          end
        end
        DIV_RUN: begin
          count <= count + 1'b1;
          if (count == CNT_W'(DIV_ITERS - 1)) begin
            state <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          o_riscv_div_result <= op_w_q ? sext_w(raw_res[31:0]) : raw_res;
          o_riscv_div_valid  <= 1'b1;
          state              <= DIV_IDLE;
        end
        default: begin
          state <= DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_riscv_div_clk) begin
    if (state == DIV_IDLE && start) begin
      op_w_q     <= op[2];
      op_rem_q   <= op[1];
      neg_quo_q  <= dvd_neg ^ dvs_neg;
      neg_rem_q  <= dvd_neg;
      div0_q     <= dvs_val == '0;
      ovf_q      <= is_signed && (dvd_val == dvd_min) && (dvs_val == '1);
      dividend_q <= dvd_val;
      divisor_q  <= dvs_neg ? -dvs_val : dvs_val;
      quo_q      <= dvd_neg ? -dvd_val : dvd_val;  // quotient bits shift in from the right.
      part_q     <= '0;
    end else if (state == DIV_RUN) begin
      quo_q  <= {quo_q[62:0], !trial[65]};
      part_q <= trial[65] ? shifted[63:0] : trial[63:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/riscv_icu.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_icu import riscv_icu_pkg::*; #(
  parameter int MUL_STAGES = 2
) (
  input  logic      i_riscv_icu_clk,
  input  logic      i_rst_n,
  input  funcsel_t  i_riscv_icu_funcsel,
  input  xlen_t     i_riscv_icu_rs1data,
  input  xlen_t     i_riscv_icu_rs2data,
  input  xlen_t     i_riscv_icu_alurs1data,
  input  xlen_t     i_riscv_icu_alurs2data,
  input  bcond_t    i_riscv_icu_bcond,
  input  mulctrl_t  i_riscv_icu_mulctrl,
  input  divctrl_t  i_riscv_icu_divctrl,
  input  alu_ctrl_t i_riscv_icu_aluctrl,
  output logic      o_riscv_branch_taken,
  output logic      o_riscv_icu_valid,
  output xlen_t     o_riscv_icu_result
);

  xlen_t alu_result;
  xlen_t mul_result;
  xlen_t div_result;
  logic  mul_valid;
  logic  div_valid;

  riscv_alu u_alu (
    .i_riscv_alu_ctrl    (i_riscv_icu_aluctrl),
    .i_riscv_alu_rs1data (i_riscv_icu_alurs1data),
    .i_riscv_alu_rs2data (i_riscv_icu_alurs2data),
    .o_riscv_alu_result  (alu_result)
  );

  riscv_branch u_branch_comp (
    .i_riscv_branch_cond    (i_riscv_icu_bcond),
    .i_riscv_branch_rs1data (i_riscv_icu_rs1data),
    .i_riscv_branch_rs2data (i_riscv_icu_rs2data),
    .o_riscv_branch_taken   (o_riscv_branch_taken)
  );

  riscv_multiplier #(
    .MUL_STAGES (MUL_STAGES)
  ) u_mul (
    .i_riscv_mul_clk     (i_riscv_icu_clk),
    .i_rst_n             (i_rst_n),
    .i_riscv_mul_rs1data (i_riscv_icu_alurs1data),
    .i_riscv_mul_rs2data (i_riscv_icu_alurs2data),
    .i_riscv_mul_mulctrl (i_riscv_icu_mulctrl),
    .o_riscv_mul_valid   (mul_valid),
    .o_riscv_mul_product (mul_result)
  );

  riscv_divider u_divider (
    .i_riscv_div_clk     (i_riscv_icu_clk),
    .i_rst_n             (i_rst_n),
    .i_riscv_div_rs1data (i_riscv_icu_alurs1data),
    .i_riscv_div_rs2data (i_riscv_icu_alurs2data),
    .i_riscv_div_divctrl (i_riscv_icu_divctrl),
    .o_riscv_div_valid   (div_valid),
    .o_riscv_div_result  (div_result)
  );

  // a multiply and a divide finishing together give a single pulse.
  assign o_riscv_icu_valid = mul_valid | div_valid;

  always_comb begin
    case (i_riscv_icu_funcsel)
      FSEL_MUL: o_riscv_icu_result = mul_result;
      FSEL_DIV: o_riscv_icu_result = div_result;
      FSEL_ALU: o_riscv_icu_result = alu_result;
      default:  o_riscv_icu_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/riscv_icu_pkg.sv */
`default_nettype none

package riscv_icu_pkg;

  typedef logic [63:0] xlen_t;     // one full register word.
  typedef logic [31:0] word_t;     // low word used by the w forms.
  typedef logic [5:0]  alu_ctrl_t;
  typedef logic [3:0]  bcond_t;    // bit 3 flags a branch, bits 2:0 are funct3.
  typedef logic [3:0]  mulctrl_t;  // bit 3 is the start strobe.
  typedef logic [3:0]  divctrl_t;  // bit 3 is the start strobe.
  typedef logic [1:0]  funcsel_t;

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

  localparam int DIV_ITERS = 64;  // one restoring step per dividend bit.

  localparam alu_ctrl_t ALU_ADD   = 6'd0;
  localparam alu_ctrl_t ALU_SUB   = 6'd1;
  localparam alu_ctrl_t ALU_SLL   = 6'd2;
  localparam alu_ctrl_t ALU_SLT   = 6'd3;
  localparam alu_ctrl_t ALU_SLTU  = 6'd4;
  localparam alu_ctrl_t ALU_XOR   = 6'd5;
  localparam alu_ctrl_t ALU_SRL   = 6'd6;
  localparam alu_ctrl_t ALU_SRA   = 6'd7;
  localparam alu_ctrl_t ALU_OR    = 6'd8;
  localparam alu_ctrl_t ALU_AND   = 6'd9;
  localparam alu_ctrl_t ALU_ADDW  = 6'd10;
  localparam alu_ctrl_t ALU_SUBW  = 6'd11;
  localparam alu_ctrl_t ALU_SLLW  = 6'd12;
  localparam alu_ctrl_t ALU_SRLW  = 6'd13;
  localparam alu_ctrl_t ALU_SRAW  = 6'd14;
  localparam alu_ctrl_t ALU_PASS2 = 6'd15;  // lui result comes in on rs2.

  localparam logic [2:0] BR_EQ  = 3'b000;
  localparam logic [2:0] BR_NE  = 3'b001;
  localparam logic [2:0] BR_LT  = 3'b100;
  localparam logic [2:0] BR_GE  = 3'b101;
  localparam logic [2:0] BR_LTU = 3'b110;
  localparam logic [2:0] BR_GEU = 3'b111;

  localparam logic [2:0] MUL_LO  = 3'd0;
  localparam logic [2:0] MUL_HSS = 3'd1;
  localparam logic [2:0] MUL_HSU = 3'd2;
  localparam logic [2:0] MUL_HUU = 3'd3;
  localparam logic [2:0] MUL_W   = 3'd4;

  // bit 0 marks unsigned, bit 1 remainder, bit 2 the word form.
  localparam logic [2:0] DIV_S  = 3'd0;
  localparam logic [2:0] DIV_U  = 3'd1;
  localparam logic [2:0] REM_S  = 3'd2;
  localparam logic [2:0] REM_U  = 3'd3;
  localparam logic [2:0] DIV_SW = 3'd4;
  localparam logic [2:0] DIV_UW = 3'd5;
  localparam logic [2:0] REM_SW = 3'd6;
  localparam logic [2:0] REM_UW = 3'd7;

  localparam funcsel_t FSEL_MUL = 2'd0;
  localparam funcsel_t FSEL_DIV = 2'd1;
  localparam funcsel_t FSEL_ALU = 2'd2;

  function automatic xlen_t sext_w(input word_t w);
    return {{32{w[31]}}, w};
  endfunction

endpackage

`default_nettype wire

/* rtl/riscv_multiplier.sv */
`default_nettype none
`timescale 1ns/1ns

module riscv_multiplier import riscv_icu_pkg::*; #(
  parameter int MUL_STAGES = 2
) (
  input  logic     i_riscv_mul_clk,
  input  logic     i_rst_n,
  input  xlen_t    i_riscv_mul_rs1data,
  input  xlen_t    i_riscv_mul_rs2data,
  input  mulctrl_t i_riscv_mul_mulctrl,
  output logic     o_riscv_mul_valid,
  output xlen_t    o_riscv_mul_product
);

  logic                  start;
  logic [2:0]            op;
  logic                  rs1_signed;
  logic                  rs2_signed;
  logic signed [64:0]    rs1_ext;
  logic signed [64:0]    rs2_ext;
  logic signed [129:0]   prod_full;
  logic [127:0]          prod_in [MUL_STAGES];
  logic [2:0]            op_in   [MUL_STAGES];
  logic [MUL_STAGES-1:0] vld_in;
  logic [127:0]          prod_q  [MUL_STAGES];
  logic [2:0]            op_q    [MUL_STAGES];
  logic [MUL_STAGES-1:0] vld_q;

  assign start      = i_riscv_mul_mulctrl[3];
  assign op         = i_riscv_mul_mulctrl[2:0];
  assign rs1_signed = (op == MUL_HSS) || (op == MUL_HSU);
  assign rs2_signed = (op == MUL_HSS);

  // one 65x65 signed multiply covers all signedness mixes.
  assign rs1_ext   = {rs1_signed & i_riscv_mul_rs1data[63], i_riscv_mul_rs1data};
  assign rs2_ext   = {rs2_signed & i_riscv_mul_rs2data[63], i_riscv_mul_rs2data};
  assign prod_full = rs1_ext * rs2_ext;

  always_comb begin
    prod_in[0] = prod_full[127:0];  // bits above 127 repeat the sign.
    op_in[0]   = op;
    vld_in[0]  = start;
    for (int k = 1; k < MUL_STAGES; k++) begin
      prod_in[k] = prod_q[k-1];
      op_in[k]   = op_q[k-1];
      vld_in[k]  = vld_q[k-1];
    end
  end

  always_ff @(posedge i_riscv_mul_clk) begin
    for (int k = 0; k < MUL_STAGES; k++) begin
      if (!i_rst_n) begin
        vld_q[k]  <= 1'b0;
        prod_q[k] <= '0;
        op_q[k]   <= MUL_LO;
      end else begin
        vld_q[k] <= vld_in[k];
        if (vld_in[k]) begin  // the last stage keeps its product until the next one.
          prod_q[k] <= prod_in[k];
          op_q[k]   <= op_in[k];
        end
      end
    end
  end

  assign o_riscv_mul_valid = vld_q[MUL_STAGES-1];

  always_comb begin
    case (op_q[MUL_STAGES-1])
      MUL_HSS, MUL_HSU, MUL_HUU: begin
        o_riscv_mul_product = prod_q[MUL_STAGES-1][127:64];
      end
      MUL_W: begin
        o_riscv_mul_product = sext_w(prod_q[MUL_STAGES-1][31:0]);
      end
      default: begin
        o_riscv_mul_product = prod_q[MUL_STAGES-1][63:0];
      end
    endcase
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the compute unit testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module riscv_icu_tb -Mdir "$BUILD_DIR" -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vriscv_icu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sim.f */
rtl/riscv_icu_pkg.sv
rtl/riscv_alu.sv
rtl/riscv_branch.sv
rtl/riscv_multiplier.sv
rtl/riscv_divider.sv
rtl/riscv_icu.sv
bench/riscv_icu_chk.sv
bench/riscv_icu_tb.sv
